/* design/vec_cfg_pkg.sv */
////////////////////////////////////////
// Vector unit configuration
// Size constants and data types shared
// by the dispatcher, sequencer and lanes
////////////////////////////////////////

`default_nettype none

package vec_cfg_pkg;

  // Lane data path is fixed at 32 bits
  localparam int unsigned ElemWidth = 32;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 8;

  // Upper bound for the MaxVl parameter
  localparam int unsigned MaxVlLimit = 64;

  typedef logic [ElemWidth-1:0] elem_t;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // Holds a length up to MaxVlLimit inclusive
  typedef logic [$clog2(MaxVlLimit+1)-1:0] vl_t;

endpackage : vec_cfg_pkg

`default_nettype wire

/* design/vec_op_pkg.sv */
////////////////////////////////////////
// Vector operations
// Opcode encoding and the decoded
// instruction handed to the sequencer
////////////////////////////////////////

`default_nettype none

package vec_op_pkg;

  import vec_cfg_pkg::*;

  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    // Broadcast scalar into vd
    VMV_VX = 3'd5,
    // Read one element of vs2, index in the scalar field
    VMV_XS = 3'd6
  } vec_op_e;

  // Decoded instruction, vl already clamped
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
    vl_t     vl;
  } vec_insn_t;

endpackage : vec_op_pkg

`default_nettype wire

/* design/pe_req_if.sv */
////////////////////////////////////////
// Sequencer to lane request bus
// Valid/ready issue broadcast, per-lane
// completion and element read data
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface pe_req_if
  import vec_cfg_pkg::*, vec_op_pkg::*;
#(
  parameter int unsigned NrLanes = 4
);

  // Broadcast side
  logic      valid;
  vec_insn_t insn;
  vl_t       idx;

  // One bit or slot per lane
  logic  [NrLanes-1:0] ready;
  logic  [NrLanes-1:0] done;
  elem_t [NrLanes-1:0] rdata;

  modport seq (
    output valid, insn, idx,
    input  ready, done, rdata
  );

  modport lane (
    input  valid, insn, idx,
    output ready, done, rdata
  );

endinterface : pe_req_if

`default_nettype wire

/* design/vec_dispatcher.sv */
////////////////////////////////////////
// Vector dispatcher
// Four-phase host handshake, decode,
// vl clamp and scalar result register
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher
  import vec_cfg_pkg::*, vec_op_pkg::*;
#(
  parameter int unsigned MaxVl = 16
) (
  input  logic      clk_i,
  input  logic      rst_i,
  // Host side
  input  logic      cmd_req_i,
  input  vec_op_e   cmd_op_i,
  input  vreg_t     cmd_vd_i,
  input  vreg_t     cmd_vs1_i,
  input  vreg_t     cmd_vs2_i,
  input  elem_t     cmd_scalar_i,
  input  vl_t       cmd_vl_i,
  output logic      cmd_ack_o,
  output elem_t     res_data_o,
  // Sequencer side
  output vec_insn_t insn_o,
  output logic      issue_valid_o,
  input  logic      issue_done_i,
  input  elem_t     rdata_i
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT, ACK} disp_state_e;

  disp_state_e state_q, state_d;
  logic        req_q;
  logic        req_rise;
  vl_t         vl_clamped;
  vec_insn_t   insn_q;
  elem_t       res_q;

  assign req_rise   = cmd_req_i & ~req_q;
  assign vl_clamped = (cmd_vl_i > vl_t'(MaxVl)) ? vl_t'(MaxVl) : cmd_vl_i;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_rise) state_d = ISSUE;
      ISSUE:   state_d = WAIT;
      WAIT:    if (issue_done_i) state_d = ACK;
      // Hold ack until the host drops req
      ACK:     if (!cmd_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= cmd_req_i;
    end
  end

  // Latch command fields on an accepted request
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_rise) begin
      insn_q.op     <= cmd_op_i;
      insn_q.vd     <= cmd_vd_i;
      insn_q.vs1    <= cmd_vs1_i;
      insn_q.vs2    <= cmd_vs2_i;
      insn_q.scalar <= cmd_scalar_i;
      insn_q.vl     <= vl_clamped;
    end
    if (state_q == WAIT && issue_done_i) begin
      res_q <= rdata_i;
    end
  end

  assign insn_o        = insn_q;
  assign issue_valid_o = (state_q == ISSUE);
  assign cmd_ack_o     = (state_q == ACK);
  assign res_data_o    = res_q;

endmodule : vec_dispatcher

`default_nettype wire

/* design/vec_sequencer.sv */
////////////////////////////////////////
// Vector sequencer
// Broadcasts one instruction to all
// lanes and collects their completion
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_sequencer
  import vec_cfg_pkg::*, vec_op_pkg::*;
#(
  parameter int unsigned NrLanes = 4
) (
  input  logic      clk_i,
  input  logic      rst_i,
  // Dispatcher side
  input  vec_insn_t insn_i,
  input  logic      issue_valid_i,
  output logic      issue_done_o,
  output elem_t     rdata_o,
  // Lanes
  pe_req_if.seq     pe
);

  localparam int unsigned LaneW = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  vec_insn_t          insn_q;
  logic               valid_q;
  logic               busy_q;
  logic               done_pulse_q;
  logic [NrLanes-1:0] acc_q;
  logic [NrLanes-1:0] done_q;
  logic [NrLanes-1:0] acc_d;
  logic [NrLanes-1:0] done_d;
  logic               all_acc;
  logic               all_done;
  logic [LaneW-1:0]   lane_sel;
  elem_t              rdata_q;

  // Masks including this cycle's responses
  assign acc_d    = acc_q | pe.ready;
  assign done_d   = done_q | pe.done;
  assign all_acc  = &acc_d;
  assign all_done = &done_d;

  assign pe.valid = valid_q;
  assign pe.insn  = insn_q;
  // Element index for VMV_XS rides in the scalar field
  assign pe.idx   = vl_t'(insn_q.scalar);

  // Element e sits in lane e mod NrLanes
  assign lane_sel = LaneW'(pe.idx % NrLanes);

  ////////////////////////////////////////
  // Accept and completion tracking
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q      <= 1'b0;
      busy_q       <= 1'b0;
      done_pulse_q <= 1'b0;
      acc_q        <= '0;
      done_q       <= '0;
    end else begin
      done_pulse_q <= 1'b0;
      if (issue_valid_i) begin
        valid_q <= 1'b1;
        busy_q  <= 1'b1;
        acc_q   <= '0;
        done_q  <= '0;
      end else if (busy_q) begin
        if (valid_q) begin
          acc_q <= acc_d;
          // Drop valid once every lane has taken it
          if (all_acc) valid_q <= 1'b0;
        end
        done_q <= done_d;
        if (all_done) begin
          busy_q       <= 1'b0;
          done_pulse_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      insn_q <= insn_i;
    end
    if (busy_q && all_done) begin
      rdata_q <= pe.rdata[lane_sel];
    end
  end

  assign issue_done_o = done_pulse_q;
  assign rdata_o      = rdata_q;

endmodule : vec_sequencer

`default_nettype wire

/* design/vec_lane.sv */
////////////////////////////////////////
// Vector lane
// Register file slice, element counter
// and integer ALU, one element a cycle
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_lane
  import vec_cfg_pkg::*, vec_op_pkg::*;
#(
  parameter int unsigned LaneId  = 0,
  parameter int unsigned NrLanes = 4,
  parameter int unsigned MaxVl   = 16
) (
  input  logic   clk_i,
  input  logic   rst_i,
  pe_req_if.lane pe
);

  // Rows of each register held by this lane
  localparam int unsigned Rows = MaxVl / NrLanes;
  localparam int unsigned RowW = (Rows > 1) ? $clog2(Rows) : 1;

  typedef logic [RowW-1:0] row_t;
  typedef enum logic [1:0] {LANE_IDLE, LANE_RUN, LANE_DONE} lane_state_e;

  lane_state_e state_q;
  row_t        row_q;
  vl_t         nr_elem;
  logic        accept;
  logic        last_row;
  elem_t       opa;
  elem_t       opb;
  elem_t       result;
  elem_t       vrf_q [NrVRegs][Rows];

  // Owned elements are row * NrLanes + LaneId, below vl
  // VMV_XS only reads, so it has no element work
  assign nr_elem = (pe.insn.op == VMV_XS) ? '0 :
                   vl_t'((32'(pe.insn.vl) + NrLanes - 1 - LaneId) / NrLanes);

  assign accept   = pe.valid & (state_q == LANE_IDLE);
  assign last_row = (vl_t'(row_q) == nr_elem - vl_t'(1));

  ////////////////////////////////////////
  // Element loop
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LANE_IDLE;
      row_q   <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (accept) begin
            row_q   <= '0;
            state_q <= (nr_elem == '0) ? LANE_DONE : LANE_RUN;
          end
        end
        LANE_RUN: begin
          row_q <= row_q + row_t'(1);
          if (last_row) state_q <= LANE_DONE;
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  assign pe.ready[LaneId] = accept;
  assign pe.done[LaneId]  = (state_q == LANE_DONE);

  ////////////////////////////////////////
  // ALU and register slice
  ////////////////////////////////////////

  assign opa = vrf_q[pe.insn.vs2][row_q];
  assign opb = vrf_q[pe.insn.vs1][row_q];

  // Subtract follows RVV, vd = vs2 - vs1
  always_comb begin
    case (pe.insn.op)
      VADD:    result = opa + opb;
      VSUB:    result = opa - opb;
      VAND:    result = opa & opb;
      VOR:     result = opa | opb;
      VXOR:    result = opa ^ opb;
      VMV_VX:  result = pe.insn.scalar;
      default: result = opa;
    endcase
  end

  // Rows at or above the lane's count are never visited
  always_ff @(posedge clk_i) begin
    if (state_q == LANE_RUN) begin
      vrf_q[pe.insn.vd][row_q] <= result;
    end
  end

  // Read port for VMV_XS, row = idx / NrLanes
  assign pe.rdata[LaneId] = vrf_q[pe.insn.vs2][row_t'(pe.idx / NrLanes)];

endmodule : vec_lane

`default_nettype wire

/* design/vec_unit.sv */
////////////////////////////////////////
// Vector coprocessor top level
// Dispatcher, sequencer and NrLanes
// parallel lanes behind a req/ack port
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_unit
  import vec_cfg_pkg::*, vec_op_pkg::*;
#(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned MaxVl   = 16
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    cmd_req_i,
  input  vec_op_e cmd_op_i,
  input  vreg_t   cmd_vd_i,
  input  vreg_t   cmd_vs1_i,
  input  vreg_t   cmd_vs2_i,
  input  elem_t   cmd_scalar_i,
  input  vl_t     cmd_vl_i,
  output logic    cmd_ack_o,
  output elem_t   res_data_o
);

  // Dispatcher to sequencer
  vec_insn_t insn;
  logic      issue_valid;
  logic      issue_done;
  elem_t     seq_rdata;

  pe_req_if #(.NrLanes(NrLanes)) pe_req ();

  vec_dispatcher #(
    .MaxVl (MaxVl)
  ) vec_dispatcher_inst (
    .clk_i         (clk_i       ),
    .rst_i         (rst_i       ),
    .cmd_req_i     (cmd_req_i   ),
    .cmd_op_i      (cmd_op_i    ),
    .cmd_vd_i      (cmd_vd_i    ),
    .cmd_vs1_i     (cmd_vs1_i   ),
    .cmd_vs2_i     (cmd_vs2_i   ),
    .cmd_scalar_i  (cmd_scalar_i),
    .cmd_vl_i      (cmd_vl_i    ),
    .cmd_ack_o     (cmd_ack_o   ),
    .res_data_o    (res_data_o  ),
    .insn_o        (insn        ),
    .issue_valid_o (issue_valid ),
    .issue_done_i  (issue_done  ),
    .rdata_i       (seq_rdata   )
  );

  vec_sequencer #(
    .NrLanes (NrLanes)
  ) vec_sequencer_inst (
    .clk_i         (clk_i      ),
    .rst_i         (rst_i      ),
    .insn_i        (insn       ),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done ),
    .rdata_o       (seq_rdata  ),
    .pe            (pe_req.seq )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId  (l      ),
      .NrLanes (NrLanes),
      .MaxVl   (MaxVl  )
    ) vec_lane_inst (
      .clk_i (clk_i      ),
      .rst_i (rst_i      ),
      .pe    (pe_req.lane)
    );
  end : gen_lanes

  // Elaboration checks on the configuration
  if (NrLanes == 0 || NrLanes > 8 || NrLanes != 2**$clog2(NrLanes)) begin : gen_chk_lanes
    $error("NrLanes must be a power of two from 1 to 8");
  end
  if (MaxVl > MaxVlLimit || MaxVl % NrLanes != 0) begin : gen_chk_vl
    $error("MaxVl must be a multiple of NrLanes and at most MaxVlLimit");
  end

endmodule : vec_unit

`default_nettype wire

/* verification/vec_unit_props.sv */
////////////////////////////////////////
// Dispatcher handshake properties
// Four-phase req/ack rules on the host
// port, bound into vec_dispatcher
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_unit_props (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic ack_i
);

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> req_i)
    else $error("cmd_ack_o rose while cmd_req_i was low");

  // Back-pressure holds the ack
  ack_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_i && req_i) |=> ack_i)
    else $error("cmd_ack_o dropped while cmd_req_i was still high");

  // Ack is released one cycle after req falls
  ack_releases: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(req_i) |=> !ack_i)
    else $error("cmd_ack_o still high after cmd_req_i fell");

endmodule : vec_unit_props

bind vec_dispatcher vec_unit_props vec_unit_props_inst (
  .clk_i (clk_i    ),
  .rst_i (rst_i    ),
  .req_i (cmd_req_i),
  .ack_i (cmd_ack_o)
);

`default_nettype wire

/* verification/vec_unit_tb.sv */
////////////////////////////////////////
// Vector unit testbench
// Directed tests over the req/ack port,
// checked against a register file model
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_unit_tb
  import vec_cfg_pkg::*, vec_op_pkg::*;
();

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned MaxVl     = 16;
  localparam int unsigned ClkPeriod = 20;
  // Instructions issued over all tests
  localparam int unsigned NrInsn    = 12 * MaxVl + 11;
  localparam int unsigned WatchdogCycles = (NrInsn + 10) * (MaxVl + 10);

  logic    clk;
  logic    rst;
  logic    cmd_req;
  vec_op_e cmd_op;
  vreg_t   cmd_vd;
  vreg_t   cmd_vs1;
  vreg_t   cmd_vs2;
  elem_t   cmd_scalar;
  vl_t     cmd_vl;
  logic    cmd_ack;
  elem_t   res_data;

  // Expected contents of the register file
  elem_t   vrf_model [NrVRegs][MaxVl];
  integer  seed = 21043;

  vec_unit #(
    .NrLanes (NrLanes),
    .MaxVl   (MaxVl  )
  ) vec_unit_inst (
    .clk_i        (clk       ),
    .rst_i        (rst       ),
    .cmd_req_i    (cmd_req   ),
    .cmd_op_i     (cmd_op    ),
    .cmd_vd_i     (cmd_vd    ),
    .cmd_vs1_i    (cmd_vs1   ),
    .cmd_vs2_i    (cmd_vs2   ),
    .cmd_scalar_i (cmd_scalar),
    .cmd_vl_i     (cmd_vl    ),
    .cmd_ack_o    (cmd_ack   ),
    .res_data_o   (res_data  )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Reporting and checking
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input elem_t got, input elem_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Subtract is vs2 minus vs1, tail elements keep their values
  task automatic model_exec(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                            input vreg_t vs2, input elem_t scalar, input vl_t vl);
    int unsigned n;
    n = (32'(vl) > MaxVl) ? MaxVl : 32'(vl);
    for (int unsigned e = 0; e < n; e++) begin
      case (op)
        VADD:    vrf_model[vd][e] = vrf_model[vs2][e] + vrf_model[vs1][e];
        VSUB:    vrf_model[vd][e] = vrf_model[vs2][e] - vrf_model[vs1][e];
        VAND:    vrf_model[vd][e] = vrf_model[vs2][e] & vrf_model[vs1][e];
        VOR:     vrf_model[vd][e] = vrf_model[vs2][e] | vrf_model[vs1][e];
        VXOR:    vrf_model[vd][e] = vrf_model[vs2][e] ^ vrf_model[vs1][e];
        VMV_VX:  vrf_model[vd][e] = scalar;
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////
  // Host handshake
  ////////////////////////////////////////

  // Four-phase transfer, req held for hold cycles after the ack
  task automatic send_insn(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                           input vreg_t vs2, input elem_t scalar, input vl_t vl,
                           input int unsigned hold, output elem_t rdata);
    int unsigned waited;
    @(posedge clk);
    #1;
    cmd_op     = op;
    cmd_vd     = vd;
    cmd_vs1    = vs1;
    cmd_vs2    = vs2;
    cmd_scalar = scalar;
    cmd_vl     = vl;
    cmd_req    = 1'b1;
    waited     = 0;
    while (!cmd_ack) begin
      @(negedge clk);
      waited++;
      if (waited > MaxVl + 10) abort_run("the DUT never acknowledged a request");
    end
    rdata = res_data;
    for (int unsigned h = 0; h < hold; h++) begin
      @(negedge clk);
      check_value("cmd_ack_o", elem_t'(cmd_ack), elem_t'(1'b1));
    end
    @(posedge clk);
    #1;
    cmd_req = 1'b0;
    waited  = 0;
    while (cmd_ack) begin
      @(negedge clk);
      waited++;
      if (waited > 2) abort_run("cmd_ack_o stayed high after cmd_req_i fell");
    end
  endtask

  task automatic exec_insn(input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                           input vreg_t vs2, input elem_t scalar, input vl_t vl,
                           input int unsigned hold);
    elem_t rdata;
    send_insn(op, vd, vs1, vs2, scalar, vl, hold, rdata);
    model_exec(op, vd, vs1, vs2, scalar, vl);
  endtask

  // Read back every element of one register
  task automatic read_all(input vreg_t vs2);
    elem_t got;
    for (int unsigned idx = 0; idx < MaxVl; idx++) begin
      send_insn(VMV_XS, '0, '0, vs2, elem_t'(idx), vl_t'(MaxVl), 0, got);
      check_value($sformatf("res_data_o (v%0d[%0d])", vs2, idx), got, vrf_model[vs2][idx]);
    end
  endtask

  // Distinct element values built from shrinking broadcasts
  task automatic fill_random(input vreg_t vd);
    for (int k = MaxVl; k >= 1; k--) begin
      exec_insn(VMV_VX, vd, '0, '0, elem_t'($random(seed)), vl_t'(k), 0);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_idle();
    repeat (5) begin
      @(negedge clk);
      check_value("cmd_ack_o", elem_t'(cmd_ack), '0);
    end
  endtask

  task automatic test_broadcast();
    exec_insn(VMV_VX, 3'd1, '0, '0, elem_t'($random(seed)), vl_t'(MaxVl), 0);
    read_all(3'd1);
  endtask

  task automatic test_alu();
    vec_op_e ops [5] = '{VADD, VSUB, VAND, VOR, VXOR};
    fill_random(3'd2);
    fill_random(3'd3);
    for (int i = 0; i < 5; i++) begin
      exec_insn(ops[i], vreg_t'(4 + i), 3'd3, 3'd2, '0, vl_t'(MaxVl), 0);
      read_all(vreg_t'(4 + i));
    end
  endtask

  // Short vl over a register already holding the VADD result
  task automatic test_tail();
    exec_insn(VXOR, 3'd4, 3'd3, 3'd2, '0, vl_t'(5), 0);
    read_all(3'd4);
  endtask

  task automatic test_clamp();
    exec_insn(VMV_VX, 3'd5, '0, '0, elem_t'($random(seed)), vl_t'(MaxVl + 20), 0);
    read_all(3'd5);
    exec_insn(VSUB, 3'd6, 3'd3, 3'd2, '0, vl_t'(100), 0);
    read_all(3'd6);
  endtask

  task automatic test_backpressure();
    exec_insn(VOR, 3'd7, 3'd3, 3'd2, '0, vl_t'(MaxVl), 6);
    exec_insn(VAND, 3'd0, 3'd2, 3'd7, '0, vl_t'(MaxVl), 0);
    read_all(3'd0);
  endtask

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin : main
    cmd_req    = 1'b0;
    cmd_op     = VADD;
    cmd_vd     = '0;
    cmd_vs1    = '0;
    cmd_vs2    = '0;
    cmd_scalar = '0;
    cmd_vl     = '0;
    rst        = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_idle();
    test_broadcast();
    test_alu();
    test_tail();
    test_clamp();
    test_backpressure();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : vec_unit_tb

`default_nettype wire

/* sources.f */
design/vec_cfg_pkg.sv
design/vec_op_pkg.sv
design/pe_req_if.sv
design/vec_dispatcher.sv
design/vec_sequencer.sv
design/vec_lane.sv
design/vec_unit.sv
verification/vec_unit_props.sv
verification/vec_unit_tb.sv

/* Makefile */
# Verilator build and run of the vector unit testbench

SIM  := obj_dir/Vvec_unit_tb
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "Run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || { echo "Run did not complete"; exit 1; }

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module vec_unit_tb -f sources.f

clean:
	rm -rf obj_dir sim.log
